// File: common/game_pkg.sv
// Game ROM package
// Download region map, SDRAM relocation bases, slot geometry and the
// packed bus types shared by the timing, download and ROM fetch blocks
`default_nettype none

package game_pkg;

    // Widths
    localparam int SDRAM_AW  = 22;
    localparam int SDRAM_DW  = 16;
    localparam int SLOT_AW   = 16;
    localparam int NUM_SLOTS = 3;
    localparam int SLOT_IW   = 2;
    localparam int PROM_AW   = 8;
    localparam int PROM_DW   = 4;

    // Byte addresses in the download stream
    localparam logic [SDRAM_AW-1:0] MAIN_START = 22'h00000;
    localparam logic [SDRAM_AW-1:0] SND_START  = 22'h20000;
    localparam logic [SDRAM_AW-1:0] CHAR_START = 22'h28000;
    localparam logic [SDRAM_AW-1:0] PROM_START = 22'h38000;
    localparam logic [SDRAM_AW-1:0] PROM_END   = PROM_START + 22'd256;

    // Word bases after relocation in SDRAM
    localparam logic [SDRAM_AW-1:0] MAIN_BASE = 22'h00000;
    localparam logic [SDRAM_AW-1:0] SND_BASE  = 22'h10000;
    localparam logic [SDRAM_AW-1:0] CHAR_BASE = 22'h20000;

    // Slot 0 main CPU, slot 1 sound CPU, slot 2 characters
    localparam logic [NUM_SLOTS-1:0][SDRAM_AW-1:0] SLOT_BASE = {
        CHAR_BASE, SND_BASE, MAIN_BASE
    };

    typedef enum logic [1:0] {
        REGION_MAIN,
        REGION_SND,
        REGION_CHAR,
        REGION_PROM
    } region_e;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_WAIT_ACK,
        ARB_WAIT_DATA
    } arb_state_e;

    typedef struct packed {
        logic               cs;
        logic [SLOT_AW-1:0] addr;
    } slot_req_t;

    typedef struct packed {
        logic                ok;
        logic [SDRAM_DW-1:0] data;
    } slot_rsp_t;

    typedef struct packed {
        logic                we;
        logic [SDRAM_AW-1:0] addr;
        logic [7:0]          data;
        logic [1:0]          mask;
    } prog_bus_t;

    typedef struct packed {
        logic                req;
        logic [SDRAM_AW-1:0] addr;
    } sdram_rd_t;

endpackage

`default_nettype wire

// File: dv/game_rom_tb.sv
// Game ROM testbench
// Directed tests for the clock enables, download relocation, game
// reset release and the cached ROM read slots behind one SDRAM port
`timescale 1ns/10ps
`default_nettype none

module game_rom_tb;

    localparam int SEED           = 23041;
    localparam int TEST_CYCLES    = 2000;
    // Twice the expected run length
    localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;
    localparam int OK_WAIT        = 40;

    logic                                          clk;
    logic                                          reset;
    logic                                          downloading;
    logic [game_pkg::SDRAM_AW-1:0]                 ioctl_addr;
    logic [7:0]                                    ioctl_data;
    logic                                          ioctl_wr;
    game_pkg::prog_bus_t                           prog;
    logic                                          prom_we;
    logic [game_pkg::PROM_AW-1:0]                  prom_addr;
    logic [game_pkg::PROM_DW-1:0]                  prom_data;
    game_pkg::slot_req_t [game_pkg::NUM_SLOTS-1:0] slot_req;
    game_pkg::slot_rsp_t [game_pkg::NUM_SLOTS-1:0] slot_rsp;
    game_pkg::sdram_rd_t                           sdram;
    logic                                          sdram_ack;
    logic                                          data_rdy;
    logic [15:0]                                   data_read;
    logic                                          refresh_en;
    logic                                          cen12;
    logic                                          cen6;
    logic                                          cen3;
    logic                                          rst_game;
    logic                                          rom_ready;

    int          errors;
    int          checks;
    int          cycles;
    logic [15:0] last_addr [game_pkg::NUM_SLOTS];

    game_rom_top u_dut (.*);

    sdram_model u_model (.*);

    always #50 clk = ~clk;

    task automatic check_eq(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("Mismatch in %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    task automatic check_true(input bit cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("%s", what);
        end
    endtask

    // SDRAM word that slot n reads for client address a
    function automatic logic [21:0] slot_word(input int n, input logic [15:0] a);
        logic [21:0] base;
        case (n)
            0:       base = game_pkg::MAIN_BASE;
            1:       base = game_pkg::SND_BASE;
            default: base = game_pkg::CHAR_BASE;
        endcase
        return base + {6'd0, a};
    endfunction

    function automatic logic [15:0] expected_data(input int n, input logic [15:0] a);
        logic [21:0] word;
        word = slot_word(n, a);
        return word[15:0] ^ 16'h5A5A;
    endfunction

    // Random address that misses the word the slot holds
    function automatic logic [15:0] pick_addr(input int n);
        logic [31:0] r;
        r = $urandom();
        if (r[15:0] == last_addr[n]) begin
            r[0] = ~r[0];
        end
        return r[15:0];
    endfunction

    task automatic count_enables();
        int         n12;
        int         n6;
        int         n3;
        logic [2:0] prev;
        logic [2:0] now;
        n12  = 0;
        n6   = 0;
        n3   = 0;
        prev = '0;
        repeat (48) begin
            @(negedge clk);
            now = {cen12, cen6, cen3};
            check_true((now & prev) == 3'b000,
                       "Clock enables: an enable pulsed in two adjacent cycles");
            if (now[2]) n12++;
            if (now[1]) n6++;
            if (now[0]) n3++;
            prev = now;
        end
        check_eq("clock enables cen12 count", 32'd12, 32'(n12));
        check_eq("clock enables cen6 count", 32'd6, 32'(n6));
        check_eq("clock enables cen3 count", 32'd3, 32'(n3));
    endtask

    task automatic drive_write(input logic [21:0] addr, input logic [7:0] data);
        @(posedge clk);
        #1;
        ioctl_addr = addr;
        ioctl_data = data;
        ioctl_wr   = 1'b1;
        @(negedge clk);
        check_eq("download strobes before the write", 32'd0, 32'({prog.we, prom_we}));
        @(posedge clk);
        #1;
        ioctl_wr = 1'b0;
        @(negedge clk);
    endtask

    task automatic write_rom_byte(input string name, input logic [21:0] addr,
                                  input logic [7:0] data, input logic [21:0] exp_addr,
                                  input logic [1:0] exp_mask);
        drive_write(addr, data);
        check_eq({name, " prog.we"}, 32'd1, 32'(prog.we));
        check_eq({name, " prog.addr"}, 32'(exp_addr), 32'(prog.addr));
        check_eq({name, " prog.mask"}, 32'(exp_mask), 32'(prog.mask));
        check_eq({name, " prog.data"}, 32'(data), 32'(prog.data));
        check_eq({name, " prom_we"}, 32'd0, 32'(prom_we));
        @(negedge clk);
        check_eq({name, " prog.we after one cycle"}, 32'd0, 32'(prog.we));
    endtask

    task automatic write_prom_byte(input logic [21:0] addr, input logic [7:0] data);
        logic [21:0] off;
        off = addr - game_pkg::PROM_START;
        drive_write(addr, data);
        check_eq("download prom prom_we", 32'd1, 32'(prom_we));
        check_eq("download prom prom_addr", 32'(off[7:0]), 32'(prom_addr));
        check_eq("download prom prom_data", 32'(data[3:0]), 32'(prom_data));
        check_eq("download prom prog.we", 32'd0, 32'(prog.we));
        @(negedge clk);
        check_eq("download prom prom_we after one cycle", 32'd0, 32'(prom_we));
    endtask

    task automatic load_regions();
        // Expected word is the region base plus half the byte offset
        // Mask 2'b10 keeps the high lane for an even byte
        write_rom_byte("download main even", 22'h00124, 8'h3C, 22'h00092, 2'b10);
        write_rom_byte("download main odd", 22'h01ABF, 8'hC5, 22'h00D5F, 2'b01);
        write_rom_byte("download sound even", 22'h20456, 8'h81, 22'h1022B, 2'b10);
        write_rom_byte("download sound odd", 22'h27FFF, 8'h7E, 22'h13FFF, 2'b01);
        write_rom_byte("download char even", 22'h28000, 8'h19, 22'h20000, 2'b10);
        write_rom_byte("download char odd", 22'h37FF1, 8'hE2, 22'h27FF8, 2'b01);
        write_prom_byte(game_pkg::PROM_START + 22'h37, 8'hA9);
    endtask

    task automatic release_reset();
        check_eq("reset release rst_game in download", 32'd1, 32'(rst_game));
        check_eq("reset release rom_ready in download", 32'd0, 32'(rom_ready));
        @(posedge clk);
        #1;
        downloading = 1'b0;
        @(negedge clk);
        check_eq("reset release rom_ready same cycle", 32'd0, 32'(rom_ready));
        @(negedge clk);
        check_eq("reset release rom_ready", 32'd1, 32'(rom_ready));
        check_eq("reset release rst_game held 1", 32'd1, 32'(rst_game));
        @(negedge clk);
        check_eq("reset release rst_game held 2", 32'd1, 32'(rst_game));
        @(negedge clk);
        check_eq("reset release rst_game", 32'd0, 32'(rst_game));
    endtask

    task automatic wait_ok(input int n, input bit watch_refresh);
        bit seen;
        seen = 1'b0;
        for (int i = 0; i < OK_WAIT; i++) begin
            @(negedge clk);
            if (slot_rsp[n].ok) begin
                seen = 1'b1;
                break;
            end
            if (watch_refresh) begin
                check_eq($sformatf("slot fetch %0d refresh_en pending", n), 32'd0,
                         32'(refresh_en));
            end
        end
        check_true(seen, $sformatf("Slot %0d gave no ok within %0d cycles", n, OK_WAIT));
    endtask

    task automatic fetch_slot(input int n, input logic [15:0] a);
        string name;
        name = $sformatf("slot fetch %0d", n);
        @(posedge clk);
        #1;
        slot_req[n].cs   = 1'b1;
        slot_req[n].addr = a;
        @(negedge clk);
        check_eq({name, " ok on miss"}, 32'd0, 32'(slot_rsp[n].ok));
        check_eq({name, " refresh_en on miss"}, 32'd0, 32'(refresh_en));
        wait_ok(n, 1'b1);
        check_eq({name, " data"}, 32'(expected_data(n, a)), 32'(slot_rsp[n].data));
        check_eq({name, " refresh_en after fill"}, 32'd1, 32'(refresh_en));
        last_addr[n] = a;
        @(posedge clk);
        #1;
        slot_req[n].cs = 1'b0;
    endtask

    task automatic fetch_each_slot();
        for (int n = 0; n < game_pkg::NUM_SLOTS; n++) begin
            fetch_slot(n, pick_addr(n));
        end
    endtask

    task automatic reuse_cached_word();
        int          count0;
        logic [15:0] a;
        a      = last_addr[0];
        count0 = u_model.req_count;
        @(posedge clk);
        #1;
        slot_req[0].cs   = 1'b1;
        slot_req[0].addr = a;
        @(negedge clk);
        check_eq("cache hit ok", 32'd1, 32'(slot_rsp[0].ok));
        check_eq("cache hit data", 32'(expected_data(0, a)), 32'(slot_rsp[0].data));
        @(posedge clk);
        #1;
        @(negedge clk);
        check_eq("cache hit ok held", 32'd1, 32'(slot_rsp[0].ok));
        a = pick_addr(0);
        @(posedge clk);
        #1;
        slot_req[0].addr = a;
        check_eq("cache hit request count", 32'(count0), 32'(u_model.req_count));
        @(negedge clk);
        check_eq("cache hit ok on new address", 32'd0, 32'(slot_rsp[0].ok));
        wait_ok(0, 1'b0);
        check_eq("cache hit refill data", 32'(expected_data(0, a)), 32'(slot_rsp[0].data));
        check_eq("cache hit refill count", 32'(count0 + 1), 32'(u_model.req_count));
        last_addr[0] = a;
        @(posedge clk);
        #1;
        slot_req[0].cs = 1'b0;
    endtask

    task automatic arbitrate_misses();
        int          count0;
        logic [15:0] a [game_pkg::NUM_SLOTS];
        count0 = u_model.req_count;
        for (int n = 0; n < game_pkg::NUM_SLOTS; n++) begin
            a[n] = pick_addr(n);
        end
        @(posedge clk);
        #1;
        // All three miss in the same cycle
        for (int n = 0; n < game_pkg::NUM_SLOTS; n++) begin
            slot_req[n].cs   = 1'b1;
            slot_req[n].addr = a[n];
        end
        for (int n = 0; n < game_pkg::NUM_SLOTS; n++) begin
            wait_ok(n, 1'b0);
        end
        check_eq("priority request count", 32'(count0 + 3), 32'(u_model.req_count));
        for (int n = 0; n < game_pkg::NUM_SLOTS; n++) begin
            check_eq($sformatf("priority request order %0d", n), 32'(slot_word(n, a[n])),
                     32'(u_model.req_log[count0 + n]));
            check_eq($sformatf("priority slot %0d data", n), 32'(expected_data(n, a[n])),
                     32'(slot_rsp[n].data));
            last_addr[n] = a[n];
        end
        @(posedge clk);
        #1;
        slot_req = '0;
    endtask

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, the tests did not finish", cycles);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        errors      = 0;
        checks      = 0;
        clk         = 1'b0;
        reset       = 1'b1;
        downloading = 1'b1;
        ioctl_addr  = '0;
        ioctl_data  = '0;
        ioctl_wr    = 1'b0;
        slot_req    = '0;
        foreach (last_addr[i]) begin
            last_addr[i] = '0;
        end
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        count_enables();
        load_regions();
        release_reset();
        fetch_each_slot();
        reuse_cached_word();
        arbitrate_misses();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/sdram_model.sv
// SDRAM read responder
// Acknowledges each read request two cycles after it is seen and
// returns the word three cycles later, keeping a count and a log of
// the requested addresses
`timescale 1ns/10ps
`default_nettype none

module sdram_model (
    input  wire                  clk,
    input  wire game_pkg::sdram_rd_t sdram,
    output logic                 sdram_ack,
    output logic                 data_rdy,
    output logic [15:0]          data_read
);

    localparam int LOG_DEPTH = 64;

    int                            req_count;
    logic [game_pkg::SDRAM_AW-1:0] req_log [LOG_DEPTH];

    task automatic serve(input logic [game_pkg::SDRAM_AW-1:0] addr);
        if (req_count < LOG_DEPTH) begin
            req_log[req_count] = addr;
        end
        req_count++;
        repeat (2) @(posedge clk);
        #1;
        sdram_ack = 1'b1;
        @(posedge clk);
        #1;
        sdram_ack = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        data_rdy  = 1'b1;
        // Word content follows its address
        data_read = addr[15:0] ^ 16'h5A5A;
        @(posedge clk);
        #1;
        data_rdy = 1'b0;
    endtask

    initial begin
        sdram_ack = 1'b0;
        data_rdy  = 1'b0;
        data_read = '0;
        req_count = 0;
        forever begin
            @(negedge clk);
            if (sdram.req) begin
                serve(sdram.addr);
            end
        end
    end

endmodule

`default_nettype wire

// File: files.f
common/game_pkg.sv
hw/clock_reset_gen.sv
hw/prom_loader.sv
rom/rom_slot.sv
rom/rom_arbiter.sv
hw/game_rom_top.sv
dv/sdram_model.sv
dv/game_rom_tb.sv

// File: hw/clock_reset_gen.sv
// Clock enables and game reset
// Derives the 12, 6 and 3 MHz enables from one counter on the 48 MHz
// clock and holds the game in reset until the ROM is ready
`timescale 1ns/10ps
`default_nettype none

module clock_reset_gen (
    input  wire  clk,
    input  wire  reset,
    input  wire  rom_ready,
    input  wire  downloading,
    output logic cen12,
    output logic cen6,
    output logic cen3,
    output logic rst_game
);

    logic [3:0] cen_cnt;
    logic       rst_dly;

    always_ff @(posedge clk) begin
        if (reset) begin
            cen_cnt <= 4'd0;
        end else begin
            cen_cnt <= cen_cnt + 4'd1;
        end
    end

    // One pulse per wrap of the relevant counter bits
    assign cen12 = &cen_cnt[1:0];
    assign cen6  = &cen_cnt[2:0];
    assign cen3  = &cen_cnt;

    // Two stage release after rom_ready, reloaded while downloading
    always_ff @(posedge clk) begin
        if (reset || !rom_ready) begin
            rst_dly  <= 1'b1;
            rst_game <= 1'b1;
        end else begin
            rst_dly  <= downloading;
            rst_game <= rst_dly;
        end
    end

endmodule

`default_nettype wire

// File: hw/game_rom_top.sv
// Game ROM top level
// Ties together the clock enable and reset unit, the download writer,
// the per slot ROM caches and the SDRAM arbiter
`timescale 1ns/10ps
`default_nettype none

module game_rom_top (
    input  wire                                             clk,
    input  wire                                             reset,
    // Download
    input  wire                                             downloading,
    input  wire  [game_pkg::SDRAM_AW-1:0]                   ioctl_addr,
    input  wire  [7:0]                                      ioctl_data,
    input  wire                                             ioctl_wr,
    output game_pkg::prog_bus_t                             prog,
    output logic                                            prom_we,
    output logic [game_pkg::PROM_AW-1:0]                    prom_addr,
    output logic [game_pkg::PROM_DW-1:0]                    prom_data,
    // ROM slots
    input  wire  game_pkg::slot_req_t [game_pkg::NUM_SLOTS-1:0] slot_req,
    output game_pkg::slot_rsp_t [game_pkg::NUM_SLOTS-1:0]   slot_rsp,
    // SDRAM read port
    output game_pkg::sdram_rd_t                             sdram,
    input  wire                                             sdram_ack,
    input  wire                                             data_rdy,
    input  wire  [game_pkg::SDRAM_DW-1:0]                   data_read,
    output logic                                            refresh_en,
    // Timing
    output logic                                            cen12,
    output logic                                            cen6,
    output logic                                            cen3,
    output logic                                            rst_game,
    output logic                                            rom_ready
);

    logic [game_pkg::NUM_SLOTS-1:0]                         need;
    logic [game_pkg::NUM_SLOTS-1:0][game_pkg::SDRAM_AW-1:0] slot_addr;
    logic [game_pkg::NUM_SLOTS-1:0]                         fill;
    logic [game_pkg::SDRAM_DW-1:0]                          fill_data;

    clock_reset_gen u_cen (
        .clk         (clk),
        .reset       (reset),
        .rom_ready   (rom_ready),
        .downloading (downloading),
        .cen12       (cen12),
        .cen6        (cen6),
        .cen3        (cen3),
        .rst_game    (rst_game)
    );

    prom_loader u_loader (
        .clk         (clk),
        .reset       (reset),
        .downloading (downloading),
        .ioctl_addr  (ioctl_addr),
        .ioctl_data  (ioctl_data),
        .ioctl_wr    (ioctl_wr),
        .prog        (prog),
        .prom_we     (prom_we),
        .prom_addr   (prom_addr),
        .prom_data   (prom_data)
    );

    for (genvar g = 0; g < game_pkg::NUM_SLOTS; g++) begin : g_slot
        rom_slot u_slot (
            .clk        (clk),
            .reset      (rst_game),
            .req        (slot_req[g]),
            .base       (game_pkg::SLOT_BASE[g]),
            .rsp        (slot_rsp[g]),
            .need       (need[g]),
            .sdram_addr (slot_addr[g]),
            .fill       (fill[g]),
            .fill_data  (fill_data)
        );
    end

    // Fixed priority SDRAM read arbiter with ready flag
    rom_arbiter u_arb (
        .clk         (clk),
        .reset       (reset),
        .downloading (downloading),
        .need        (need),
        .slot_addr   (slot_addr),
        .sdram       (sdram),
        .sdram_ack   (sdram_ack),
        .data_rdy    (data_rdy),
        .data_read   (data_read),
        .fill        (fill),
        .fill_data   (fill_data),
        .refresh_en  (refresh_en),
        .rom_ready   (rom_ready)
    );

endmodule

`default_nettype wire

// File: hw/prom_loader.sv
// Download writer
// Sorts the download byte stream into ROM regions, relocates them to
// their SDRAM word bases with byte lane masks, and diverts the priority
// PROM bytes to a separate write strobe
`timescale 1ns/10ps
`default_nettype none

module prom_loader (
    input  wire                              clk,
    input  wire                              reset,
    input  wire                              downloading,
    input  wire  [game_pkg::SDRAM_AW-1:0]    ioctl_addr,
    input  wire  [7:0]                       ioctl_data,
    input  wire                              ioctl_wr,
    output game_pkg::prog_bus_t              prog,
    output logic                             prom_we,
    output logic [game_pkg::PROM_AW-1:0]     prom_addr,
    output logic [game_pkg::PROM_DW-1:0]     prom_data
);

    game_pkg::region_e                 region;
    logic [game_pkg::SDRAM_AW-1:0]     region_start;
    logic [game_pkg::SDRAM_AW-1:0]     region_base;
    logic [game_pkg::SDRAM_AW-1:0]     offset;
    logic                              in_range;
    logic                              rom_wr;
    logic                              prom_wr;
    logic                              prog_we;
    logic [game_pkg::SDRAM_AW-1:0]     prog_addr;
    logic [7:0]                        prog_data;
    logic [1:0]                        prog_mask;

    always_comb begin
        if (ioctl_addr < game_pkg::SND_START) begin
            region       = game_pkg::REGION_MAIN;
            region_start = game_pkg::MAIN_START;
            region_base  = game_pkg::MAIN_BASE;
        end else if (ioctl_addr < game_pkg::CHAR_START) begin
            region       = game_pkg::REGION_SND;
            region_start = game_pkg::SND_START;
            region_base  = game_pkg::SND_BASE;
        end else if (ioctl_addr < game_pkg::PROM_START) begin
            region       = game_pkg::REGION_CHAR;
            region_start = game_pkg::CHAR_START;
            region_base  = game_pkg::CHAR_BASE;
        end else begin
            // PROM bytes stay on chip
            region       = game_pkg::REGION_PROM;
            region_start = game_pkg::PROM_START;
            region_base  = '0;
        end
    end

    assign offset   = ioctl_addr - region_start;
    assign in_range = ioctl_addr < game_pkg::PROM_END;
    assign rom_wr   = ioctl_wr && downloading && (region != game_pkg::REGION_PROM);
    assign prom_wr  = ioctl_wr && downloading && in_range
                      && (region == game_pkg::REGION_PROM);

    always_ff @(posedge clk) begin
        if (reset) begin
            prog_we <= 1'b0;
            prom_we <= 1'b0;
        end else begin
            prog_we <= rom_wr;
            prom_we <= prom_wr;
        end
    end

    always_ff @(posedge clk) begin
        if (ioctl_wr) begin
            prog_addr <= region_base + (offset >> 1);
            prog_data <= ioctl_data;
            // Even byte lands in the low lane, so the high lane is kept
            prog_mask <= offset[0] ? 2'b01 : 2'b10;
            prom_addr <= offset[game_pkg::PROM_AW-1:0];
            prom_data <= ioctl_data[game_pkg::PROM_DW-1:0];
        end
    end

    assign prog = '{we: prog_we, addr: prog_addr, data: prog_data, mask: prog_mask};

endmodule

`default_nettype wire

// File: rom/rom_arbiter.sv
// ROM arbiter
// Shares one SDRAM read port between the slots with fixed priority,
// lowest slot first. Also flags ROM ready after the download and
// tells the SDRAM controller when it may refresh
`timescale 1ns/10ps
`default_nettype none

module rom_arbiter (
    input  wire                                                  clk,
    input  wire                                                  reset,
    input  wire                                                  downloading,
    input  wire  [game_pkg::NUM_SLOTS-1:0]                       need,
    input  wire  [game_pkg::NUM_SLOTS-1:0][game_pkg::SDRAM_AW-1:0] slot_addr,
    output game_pkg::sdram_rd_t                                  sdram,
    input  wire                                                  sdram_ack,
    input  wire                                                  data_rdy,
    input  wire  [game_pkg::SDRAM_DW-1:0]                        data_read,
    output logic [game_pkg::NUM_SLOTS-1:0]                       fill,
    output logic [game_pkg::SDRAM_DW-1:0]                        fill_data,
    output logic                                                 refresh_en,
    output logic                                                 rom_ready
);

    game_pkg::arb_state_e            state;
    logic [game_pkg::SLOT_IW-1:0]    sel_idx;
    logic [game_pkg::SLOT_IW-1:0]    grant_idx;
    logic [game_pkg::SDRAM_AW-1:0]   grant_addr;
    logic                            any_need;
    logic                            start;

    assign any_need = |need;
    assign start    = (state == game_pkg::ARB_IDLE) && rom_ready && any_need;

    // Scan downwards so the lowest requesting slot wins
    always_comb begin
        sel_idx = '0;
        for (int i = game_pkg::NUM_SLOTS - 1; i >= 0; i--) begin
            if (need[i]) begin
                sel_idx = i[game_pkg::SLOT_IW-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= game_pkg::ARB_IDLE;
            rom_ready <= 1'b0;
        end else begin
            rom_ready <= !downloading;
            case (state)
                game_pkg::ARB_IDLE: begin
                    if (start) begin
                        state <= game_pkg::ARB_WAIT_ACK;
                    end
                end
                game_pkg::ARB_WAIT_ACK: begin
                    if (sdram_ack) begin
                        state <= game_pkg::ARB_WAIT_DATA;
                    end
                end
                game_pkg::ARB_WAIT_DATA: begin
                    if (data_rdy) begin
                        state <= game_pkg::ARB_IDLE;
                    end
                end
                default: state <= game_pkg::ARB_IDLE;
            endcase
        end
    end

    // Grant held for the whole access so other misses simply wait
    always_ff @(posedge clk) begin
        if (start) begin
            grant_idx  <= sel_idx;
            grant_addr <= slot_addr[sel_idx];
        end
    end

    assign sdram = '{req: state == game_pkg::ARB_WAIT_ACK, addr: grant_addr};

    always_comb begin
        fill = '0;
        if ((state == game_pkg::ARB_WAIT_DATA) && data_rdy) begin
            fill[grant_idx] = 1'b1;
        end
    end

    assign fill_data  = data_read;
    assign refresh_en = (state == game_pkg::ARB_IDLE) && !any_need;

endmodule

`default_nettype wire

// File: rom/rom_slot.sv
// ROM read slot
// Holds one cached SDRAM word for a client. A hit answers at once,
// a miss raises need towards the arbiter until the word is filled
`timescale 1ns/10ps
`default_nettype none

module rom_slot (
    input  wire                              clk,
    input  wire                              reset,
    input  wire  game_pkg::slot_req_t        req,
    input  wire  [game_pkg::SDRAM_AW-1:0]    base,
    output game_pkg::slot_rsp_t              rsp,
    output logic                             need,
    output logic [game_pkg::SDRAM_AW-1:0]    sdram_addr,
    input  wire                              fill,
    input  wire  [game_pkg::SDRAM_DW-1:0]    fill_data
);

    localparam int PAD_W = game_pkg::SDRAM_AW - game_pkg::SLOT_AW;

    logic [game_pkg::SLOT_AW-1:0]  cache_addr;
    logic [game_pkg::SDRAM_DW-1:0] cache_data;
    logic                          valid;
    logic                          hit;
    // Address of the word the arbiter was asked for
    logic [game_pkg::SLOT_AW-1:0]  pend_addr;
    logic                          pending;
    logic [game_pkg::SLOT_AW-1:0]  fetch_addr;

    assign hit  = valid && (cache_addr == req.addr);
    assign need = req.cs && !hit;
    assign rsp  = '{ok: req.cs && hit, data: cache_data};

    // Keep presenting the latched address while a fetch is in flight
    assign fetch_addr = pending ? pend_addr : req.addr;
    assign sdram_addr = base + {{PAD_W{1'b0}}, fetch_addr};

    always_ff @(posedge clk) begin
        if (reset) begin
            valid   <= 1'b0;
            pending <= 1'b0;
        end else begin
            if (fill) begin
                valid   <= 1'b1;
                pending <= 1'b0;
            end else if (need && !pending) begin
                pending <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (need && !pending) begin
            pend_addr <= req.addr;
        end
        if (fill) begin
            cache_addr <= pend_addr;
            cache_data <= fill_data;
        end
    end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build the game ROM testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f files.f --top-module game_rom_tb -o game_rom_sim \
    || { echo "Build failed"; exit 1; }
out=$(./obj_dir/game_rom_sim)
echo "$out"
echo "$out" | grep -q "TEST RESULT: PASS" && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
